/* src/axi_slice_cfg.svh */
// AXI4 register slice configuration: bus widths, memory depth and skid output option
`ifndef AXI_SLICE_CFG_SVH
`define AXI_SLICE_CFG_SVH

// Byte address width on both sides of the slice
`define AXI_ADDR_WIDTH 32

// Data bus width in bits, one full word per beat
`define AXI_DATA_WIDTH 32

// Transaction id width, echoed on B and R
`define AXI_ID_WIDTH 4

// Depth of the on-chip memory in bus words, 256 words give 1 KiB
`define MEM_WORDS 256

// Set to 1 so that valid and payload leave every skid buffer from flops
`define SKID_REGISTER_OUTPUT 1

`endif

/* src/axi_slice_pkg.sv */
// AXI4 slice types: channel payload structs, burst and response codes, memory engine states
`default_nettype none

`include "axi_slice_cfg.svh"

package axi_slice_pkg;

    // Burst type as carried on AWBURST and ARBURST
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // Response code as carried on BRESP and RRESP
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // States of the memory's write and read engines
    typedef enum logic [1:0] {
        MEM_IDLE   = 2'b00,
        MEM_ACTIVE = 2'b01,
        MEM_RESP   = 2'b10
    } mem_state_e;

    // AW and AR payload, the lock, cache, prot and qos fields only pass through
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        axi_burst_e                 burst;
        logic [1:0]                 lock;
        logic [3:0]                 cache;
        logic [2:0]                 prot;
        logic [3:0]                 qos;
    } axi_addr_t;

    // W payload, one strobe bit per data byte
    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0]   data;
        logic [`AXI_DATA_WIDTH/8-1:0] strb;
        logic                         last;
    } axi_wdata_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0] id;
        axi_resp_e                resp;
    } axi_bresp_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_DATA_WIDTH-1:0] data;
        axi_resp_e                  resp;
        logic                       last;
    } axi_rdata_t;

endpackage

`default_nettype wire

/* src/axi_skid_buffer.sv */
// AXI4 skid buffer: cuts the valid, ready and payload paths of a single channel
`default_nettype none

module axi_skid_buffer #(
    parameter type payload_t       = logic,
    parameter bit  REGISTER_OUTPUT = 1'b1
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     ready_armed;
    logic     skidding;
    payload_t skid_data;
    logic     accept;
    logic     stalled;

    assign accept   = in_valid && in_ready;
    assign stalled  = out_valid && !out_ready;
    assign in_ready = ready_armed && !skidding;

    // Keeps in_ready low through reset and for the first cycle after it
    always_ff @(posedge clock) begin
        if (!reset) begin
            ready_armed <= 1'b0;
        end else begin
            ready_armed <= 1'b1;
        end
    end

    // A beat accepted while the output stalls is parked until the stall clears
    always_ff @(posedge clock) begin
        if (!reset) begin
            skidding <= 1'b0;
        end else if (accept && stalled) begin
            skidding <= 1'b1;
        end else if (out_ready) begin
            skidding <= 1'b0;
        end
    end

    // The skid register follows the input as long as nothing is parked in it
    always_ff @(posedge clock) begin
        if (in_ready) begin
            skid_data <= in_data;
        end
    end

    if (REGISTER_OUTPUT) begin : gen_registered
        logic     valid_q;
        payload_t data_q;

        // Output flops reload whenever they are empty or being drained
        always_ff @(posedge clock) begin
            if (!reset) begin
                valid_q <= 1'b0;
            end else if (!valid_q || out_ready) begin
                valid_q <= skidding || accept;
            end
        end

        // A parked beat is older than anything at the input, so it goes first
        always_ff @(posedge clock) begin
            if (!valid_q || out_ready) begin
                data_q <= skidding ? skid_data : in_data;
            end
        end

        assign out_valid = valid_q;
        assign out_data  = data_q;
    end else begin : gen_bypass
        // Only the ready path is cut here; valid and data flow straight through
        assign out_valid = skidding || accept;
        assign out_data  = skidding ? skid_data : in_data;
    end

endmodule

`default_nettype wire

/* src/axi_register_slice.sv */
// AXI4 register slice: one skid buffer on each of the five channels
`default_nettype none

`include "axi_slice_cfg.svh"

module axi_register_slice
    import axi_slice_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    // Master side
    input  logic       s_aw_valid,
    output logic       s_aw_ready,
    input  axi_addr_t  s_aw,
    input  logic       s_w_valid,
    output logic       s_w_ready,
    input  axi_wdata_t s_w,
    output logic       s_b_valid,
    input  logic       s_b_ready,
    output axi_bresp_t s_b,
    input  logic       s_ar_valid,
    output logic       s_ar_ready,
    input  axi_addr_t  s_ar,
    output logic       s_r_valid,
    input  logic       s_r_ready,
    output axi_rdata_t s_r,
    // Slave side
    output logic       m_aw_valid,
    input  logic       m_aw_ready,
    output axi_addr_t  m_aw,
    output logic       m_w_valid,
    input  logic       m_w_ready,
    output axi_wdata_t m_w,
    input  logic       m_b_valid,
    output logic       m_b_ready,
    input  axi_bresp_t m_b,
    output logic       m_ar_valid,
    input  logic       m_ar_ready,
    output axi_addr_t  m_ar,
    input  logic       m_r_valid,
    output logic       m_r_ready,
    input  axi_rdata_t m_r
);

    localparam bit REGISTER_OUTPUT = `SKID_REGISTER_OUTPUT;

    // Forward channels run from the master side towards the slave
    axi_skid_buffer #(.payload_t(axi_addr_t), .REGISTER_OUTPUT(REGISTER_OUTPUT)) aw_buffer (
        .clock(clock), .reset(reset),
        .in_valid(s_aw_valid), .in_ready(s_aw_ready), .in_data(s_aw),
        .out_valid(m_aw_valid), .out_ready(m_aw_ready), .out_data(m_aw)
    );

    axi_skid_buffer #(.payload_t(axi_wdata_t), .REGISTER_OUTPUT(REGISTER_OUTPUT)) w_buffer (
        .clock(clock), .reset(reset),
        .in_valid(s_w_valid), .in_ready(s_w_ready), .in_data(s_w),
        .out_valid(m_w_valid), .out_ready(m_w_ready), .out_data(m_w)
    );

    axi_skid_buffer #(.payload_t(axi_addr_t), .REGISTER_OUTPUT(REGISTER_OUTPUT)) ar_buffer (
        .clock(clock), .reset(reset),
        .in_valid(s_ar_valid), .in_ready(s_ar_ready), .in_data(s_ar),
        .out_valid(m_ar_valid), .out_ready(m_ar_ready), .out_data(m_ar)
    );

    // Responses come back from the slave, so these two buffers face the other way
    axi_skid_buffer #(.payload_t(axi_bresp_t), .REGISTER_OUTPUT(REGISTER_OUTPUT)) b_buffer (
        .clock(clock), .reset(reset),
        .in_valid(m_b_valid), .in_ready(m_b_ready), .in_data(m_b),
        .out_valid(s_b_valid), .out_ready(s_b_ready), .out_data(s_b)
    );

    axi_skid_buffer #(.payload_t(axi_rdata_t), .REGISTER_OUTPUT(REGISTER_OUTPUT)) r_buffer (
        .clock(clock), .reset(reset),
        .in_valid(m_r_valid), .in_ready(m_r_ready), .in_data(m_r),
        .out_valid(s_r_valid), .out_ready(s_r_ready), .out_data(s_r)
    );

endmodule

`default_nettype wire

/* src/axi_burst_memory.sv */
// AXI4 burst memory: word-wide slave with FIXED, INCR and WRAP bursts and strobed writes
`default_nettype none

`include "axi_slice_cfg.svh"

module axi_burst_memory
    import axi_slice_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  axi_addr_t  aw,
    input  logic       w_valid,
    output logic       w_ready,
    input  axi_wdata_t w,
    output logic       b_valid,
    input  logic       b_ready,
    output axi_bresp_t b,
    input  logic       ar_valid,
    output logic       ar_ready,
    input  axi_addr_t  ar,
    output logic       r_valid,
    input  logic       r_ready,
    output axi_rdata_t r
);

    localparam int BYTES     = `AXI_DATA_WIDTH / 8;
    localparam int BYTE_BITS = $clog2(BYTES);
    localparam int WORD_BITS = $clog2(`MEM_WORDS);

    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;

    logic [`AXI_DATA_WIDTH-1:0] mem [`MEM_WORDS];

    mem_state_e               wr_state;
    logic [`AXI_ID_WIDTH-1:0] wr_id;
    addr_t                    wr_addr;
    logic [7:0]               wr_len;
    axi_burst_e               wr_burst;
    logic                     wr_slverr;
    logic                     wr_decerr;

    mem_state_e               rd_state;
    logic [`AXI_ID_WIDTH-1:0] rd_id;
    addr_t                    rd_addr;
    logic [7:0]               rd_len;
    logic [7:0]               rd_count;
    axi_burst_e               rd_burst;
    logic                     rd_slverr;

    function automatic logic in_range(input addr_t addr);
        return (addr >> BYTE_BITS) < addr_t'(`MEM_WORDS);
    endfunction

    function automatic logic [WORD_BITS-1:0] word_index(input addr_t addr);
        return addr[BYTE_BITS +: WORD_BITS];
    endfunction

    // Address of the following beat; WRAP stays inside a (len+1) word window
    function automatic addr_t next_addr(input addr_t addr, input logic [7:0] len,
                                        input axi_burst_e burst);
        addr_t step;
        addr_t mask;
        step = addr + addr_t'(BYTES);
        mask = ((addr_t'(len) + 1'b1) << BYTE_BITS) - 1'b1;
        case (burst)
            FIXED:   return addr;
            WRAP:    return (addr & ~mask) | (step & mask);
            default: return step;
        endcase
    endfunction

    // Narrow sizes, odd WRAP lengths and the reserved burst code are all SLVERR
    function automatic logic request_error(input axi_addr_t req);
        logic size_bad;
        logic wrap_bad;
        size_bad = req.size != 3'(BYTE_BITS);
        wrap_bad = (req.burst == WRAP) && !(req.len inside {8'd1, 8'd3, 8'd7, 8'd15});
        return size_bad || wrap_bad || !(req.burst inside {FIXED, INCR, WRAP});
    endfunction

    assign aw_ready = wr_state == MEM_IDLE;
    assign w_ready  = wr_state == MEM_ACTIVE;
    assign b_valid  = wr_state == MEM_RESP;

    always_comb begin
        b.id   = wr_id;
        b.resp = OKAY;
        if (wr_slverr) begin
            b.resp = SLVERR;
        end else if (wr_decerr) begin
            b.resp = DECERR;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_state  <= MEM_IDLE;
            wr_slverr <= 1'b0;
            wr_decerr <= 1'b0;
        end else begin
            case (wr_state)
                MEM_IDLE: if (aw_valid) begin
                    wr_state  <= MEM_ACTIVE;
                    wr_slverr <= request_error(aw);
                    wr_decerr <= 1'b0;
                end
                MEM_ACTIVE: if (w_valid) begin
                    // Any beat outside the array turns the whole write into DECERR
                    if (!in_range(wr_addr)) begin
                        wr_decerr <= 1'b1;
                    end
                    if (w.last) begin
                        wr_state <= MEM_RESP;
                    end
                end
                default: if (b_ready) begin
                    wr_state <= MEM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_valid && aw_ready) begin
            wr_id    <= aw.id;
            wr_addr  <= aw.addr;
            wr_len   <= aw.len;
            wr_burst <= aw.burst;
        end else if (w_valid && w_ready) begin
            wr_addr <= next_addr(wr_addr, wr_len, wr_burst);
        end
    end

    // Only strobed bytes of in-range beats are written, and nothing on SLVERR
    always_ff @(posedge clock) begin
        if (w_valid && w_ready && !wr_slverr && in_range(wr_addr)) begin
            for (int i = 0; i < BYTES; i++) begin
                if (w.strb[i]) begin
                    mem[word_index(wr_addr)][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    // The read engine shows its final beat in MEM_RESP, so last is just the state
    assign ar_ready = rd_state == MEM_IDLE;
    assign r_valid  = rd_state != MEM_IDLE;

    always_comb begin
        r.id   = rd_id;
        r.last = rd_state == MEM_RESP;
        r.data = '0;
        r.resp = OKAY;
        if (rd_slverr) begin
            r.resp = SLVERR;
        end else if (!in_range(rd_addr)) begin
            r.resp = DECERR;
        end else begin
            r.data = mem[word_index(rd_addr)];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_state  <= MEM_IDLE;
            rd_slverr <= 1'b0;
        end else begin
            case (rd_state)
                MEM_IDLE: if (ar_valid) begin
                    rd_state  <= (ar.len == 8'd0) ? MEM_RESP : MEM_ACTIVE;
                    rd_slverr <= request_error(ar);
                end
                MEM_ACTIVE: if (r_ready && rd_count == rd_len - 8'd1) begin
                    rd_state <= MEM_RESP;
                end
                default: if (r_ready) begin
                    rd_state <= MEM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (ar_valid && ar_ready) begin
            rd_id    <= ar.id;
            rd_addr  <= ar.addr;
            rd_len   <= ar.len;
            rd_burst <= ar.burst;
            rd_count <= 8'd0;
        end else if (r_valid && r_ready) begin
            rd_addr  <= next_addr(rd_addr, rd_len, rd_burst);
            rd_count <= rd_count + 8'd1;
        end
    end

endmodule

`default_nettype wire

/* src/axi_slice_top.sv */
// AXI4 slice top: register slice in front of the burst memory, master port exposed
`default_nettype none

module axi_slice_top
    import axi_slice_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       s_aw_valid,
    output logic       s_aw_ready,
    input  axi_addr_t  s_aw,
    input  logic       s_w_valid,
    output logic       s_w_ready,
    input  axi_wdata_t s_w,
    output logic       s_b_valid,
    input  logic       s_b_ready,
    output axi_bresp_t s_b,
    input  logic       s_ar_valid,
    output logic       s_ar_ready,
    input  axi_addr_t  s_ar,
    output logic       s_r_valid,
    input  logic       s_r_ready,
    output axi_rdata_t s_r
);

    // Slave-side channels between the slice and the memory
    logic       mem_aw_valid;
    logic       mem_aw_ready;
    axi_addr_t  mem_aw;
    logic       mem_w_valid;
    logic       mem_w_ready;
    axi_wdata_t mem_w;
    logic       mem_b_valid;
    logic       mem_b_ready;
    axi_bresp_t mem_b;
    logic       mem_ar_valid;
    logic       mem_ar_ready;
    axi_addr_t  mem_ar;
    logic       mem_r_valid;
    logic       mem_r_ready;
    axi_rdata_t mem_r;

    axi_register_slice slice (
        .clock(clock), .reset(reset),
        .s_aw_valid(s_aw_valid), .s_aw_ready(s_aw_ready), .s_aw(s_aw),
        .s_w_valid(s_w_valid), .s_w_ready(s_w_ready), .s_w(s_w),
        .s_b_valid(s_b_valid), .s_b_ready(s_b_ready), .s_b(s_b),
        .s_ar_valid(s_ar_valid), .s_ar_ready(s_ar_ready), .s_ar(s_ar),
        .s_r_valid(s_r_valid), .s_r_ready(s_r_ready), .s_r(s_r),
        .m_aw_valid(mem_aw_valid), .m_aw_ready(mem_aw_ready), .m_aw(mem_aw),
        .m_w_valid(mem_w_valid), .m_w_ready(mem_w_ready), .m_w(mem_w),
        .m_b_valid(mem_b_valid), .m_b_ready(mem_b_ready), .m_b(mem_b),
        .m_ar_valid(mem_ar_valid), .m_ar_ready(mem_ar_ready), .m_ar(mem_ar),
        .m_r_valid(mem_r_valid), .m_r_ready(mem_r_ready), .m_r(mem_r)
    );

    axi_burst_memory memory (
        .clock(clock), .reset(reset),
        .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready), .aw(mem_aw),
        .w_valid(mem_w_valid), .w_ready(mem_w_ready), .w(mem_w),
        .b_valid(mem_b_valid), .b_ready(mem_b_ready), .b(mem_b),
        .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready), .ar(mem_ar),
        .r_valid(mem_r_valid), .r_ready(mem_r_ready), .r(mem_r)
    );

endmodule

`default_nettype wire

/* verification/axi_slice_checker.sv */
// AXI4 handshake checker: reset values and payload stability on the register slice outputs
`default_nettype none

module axi_slice_checker
    import axi_slice_pkg::*;
(
    input logic       clock,
    input logic       reset,
    input logic       s_aw_ready,
    input logic       m_aw_valid,
    input logic       m_aw_ready,
    input axi_addr_t  m_aw,
    input logic       m_w_valid,
    input logic       m_w_ready,
    input axi_wdata_t m_w,
    input logic       m_ar_valid,
    input logic       m_ar_ready,
    input axi_addr_t  m_ar,
    input logic       s_b_valid,
    input logic       s_b_ready,
    input axi_bresp_t s_b,
    input logic       s_r_valid,
    input logic       s_r_ready,
    input axi_rdata_t s_r
);
    timeunit 1ns;
    timeprecision 100ps;

    // Counts failed assertions so the testbench can see them at the end
    int unsigned failures = 0;

    // Every output valid of the slice is cleared while reset is held
    valids_cleared: assert property (@(posedge clock)
        !reset |=> !(m_aw_valid || m_w_valid || m_ar_valid || s_b_valid || s_r_valid))
        else begin failures++; $error("A channel valid was high after reset"); end

    // The AW buffer refuses beats in the first cycle after reset
    aw_ready_late: assert property (@(posedge clock) $rose(reset) |-> !s_aw_ready)
        else begin failures++; $error("AW ready was high right after reset"); end

    // A beat that is offered and not taken stays put until it is taken
    aw_held: assert property (@(posedge clock) disable iff (!reset)
        m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw))
        else begin failures++; $error("AW beat changed while stalled"); end

    w_held: assert property (@(posedge clock) disable iff (!reset)
        m_w_valid && !m_w_ready |=> m_w_valid && $stable(m_w))
        else begin failures++; $error("W beat changed while stalled"); end

    ar_held: assert property (@(posedge clock) disable iff (!reset)
        m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar))
        else begin failures++; $error("AR beat changed while stalled"); end

    b_held: assert property (@(posedge clock) disable iff (!reset)
        s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b))
        else begin failures++; $error("B beat changed while stalled"); end

    r_held: assert property (@(posedge clock) disable iff (!reset)
        s_r_valid && !s_r_ready |=> s_r_valid && $stable(s_r))
        else begin failures++; $error("R beat changed while stalled"); end

endmodule

bind axi_register_slice axi_slice_checker handshake_checks (.*);

`default_nettype wire

/* verification/axi_slice_tb.sv */
// AXI4 slice testbench: drives bursts through the slice and checks B and R against a memory model
`default_nettype none

`include "axi_slice_cfg.svh"

module axi_slice_tb
    import axi_slice_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BYTES   = `AXI_DATA_WIDTH / 8;
    localparam int TIMEOUT = 2000;

    logic       clock = 1'b0;
    logic       reset;
    logic       s_aw_valid;
    logic       s_aw_ready;
    axi_addr_t  s_aw;
    logic       s_w_valid;
    logic       s_w_ready;
    axi_wdata_t s_w;
    logic       s_b_valid;
    logic       s_b_ready = 1'b1;
    axi_bresp_t s_b;
    logic       s_ar_valid;
    logic       s_ar_ready;
    axi_addr_t  s_ar;
    logic       s_r_valid;
    logic       s_r_ready = 1'b1;
    axi_rdata_t s_r;

    // Byte-wide model of the memory behind the slice
    logic [7:0]                 model_mem [`MEM_WORDS * BYTES];
    logic [`AXI_DATA_WIDTH-1:0] beat_data [16];
    logic [BYTES-1:0]           beat_strb [16];
    axi_rdata_t                 exp_r [$];
    axi_bresp_t                 exp_b [$];
    axi_addr_t                  wr_reqs [6];
    axi_addr_t                  rd_reqs [6];
    axi_addr_t                  req;
    int                         len;
    int                         word;
    bit                         backpressure = 1'b0;
    string                      test_name = "reset";

    axi_slice_top i_dut (.*);

    always #2 clock = ~clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic axi_addr_t make_req(input logic [3:0] id, input int first_word,
                                           input int beats_minus_one, input axi_burst_e burst);
        axi_addr_t r;
        r       = '0;
        r.id    = id;
        r.addr  = 32'(first_word * BYTES);
        r.len   = 8'(beats_minus_one);
        r.size  = 3'($clog2(BYTES));
        r.burst = burst;
        r.cache = 4'h3;
        return r;
    endfunction

    function automatic bit mapped(input logic [31:0] addr);
        return addr < 32'(`MEM_WORDS * BYTES);
    endfunction

    // Byte address of beat n; a WRAP burst cycles through an aligned window of len+1 words
    function automatic logic [31:0] beat_addr(input axi_addr_t r, input int n);
        logic [31:0] window;
        logic [31:0] lower;
        window = (32'(r.len) + 32'd1) * 32'(BYTES);
        lower  = r.addr - (r.addr % window);
        case (r.burst)
            FIXED:   return r.addr;
            WRAP:    return lower + ((r.addr - lower + 32'(n * BYTES)) % window);
            default: return r.addr + 32'(n * BYTES);
        endcase
    endfunction

    function automatic axi_resp_e request_resp(input axi_addr_t r);
        if (r.size != 3'($clog2(BYTES))) begin
            return SLVERR;
        end
        if (r.burst == WRAP && !(r.len inside {8'd1, 8'd3, 8'd7, 8'd15})) begin
            return SLVERR;
        end
        return OKAY;
    endfunction

    // Reference for beat n of a read, taken from the model as it stands
    function automatic axi_rdata_t expected_read(input axi_addr_t r, input int n);
        axi_rdata_t beat;
        logic [31:0] addr;
        addr      = beat_addr(r, n);
        beat.id   = r.id;
        beat.last = n == int'(r.len);
        beat.resp = request_resp(r);
        beat.data = '0;
        if (beat.resp == OKAY && !mapped(addr)) begin
            beat.resp = DECERR;
        end else if (beat.resp == OKAY) begin
            for (int i = 0; i < BYTES; i++) begin
                beat.data[8*i +: 8] = model_mem[addr + 32'(i)];
            end
        end
        return beat;
    endfunction

    function automatic axi_bresp_t expected_write(input axi_addr_t r);
        axi_bresp_t rsp;
        rsp.id   = r.id;
        rsp.resp = request_resp(r);
        for (int n = 0; n <= int'(r.len); n++) begin
            if (rsp.resp == OKAY && !mapped(beat_addr(r, n))) begin
                rsp.resp = DECERR;
            end
        end
        return rsp;
    endfunction

    // Strobed bytes of mapped beats land in the model, a rejected request changes nothing
    function automatic void apply_write(input axi_addr_t r);
        logic [31:0] addr;
        if (request_resp(r) != OKAY) begin
            return;
        end
        for (int n = 0; n <= int'(r.len); n++) begin
            addr = beat_addr(r, n);
            for (int i = 0; i < BYTES; i++) begin
                if (mapped(addr) && beat_strb[n][i]) begin
                    model_mem[addr + 32'(i)] = beat_data[n][8*i +: 8];
                end
            end
        end
    endfunction

    function automatic void random_beats(input int beats_minus_one);
        for (int i = 0; i <= beats_minus_one; i++) begin
            beat_data[i] = $urandom;
            beat_strb[i] = BYTES'($urandom);
        end
    endfunction

    function automatic logic ready_of(input int channel);
        case (channel)
            0:       return s_aw_ready;
            1:       return s_w_ready;
            default: return s_ar_ready;
        endcase
    endfunction

    // Called just after valid is driven, returns just after the transfer edge
    task automatic handshake(input int channel, input string what);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!ready_of(channel)) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run({"Timed out waiting for ", what, " in test ", test_name});
            end
            @(negedge clock);
        end
        @(posedge clock);
        #0.5;
    endtask

    task automatic wait_responses(input bit reads, input string what);
        int cycles;
        cycles = 0;
        while ((reads ? exp_r.size() : exp_b.size()) != 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run({"Timed out waiting for ", what, " in test ", test_name});
            end
        end
        @(posedge clock);
        #0.5;
    endtask

    // Hands over the address and every data beat, the response is left outstanding
    task automatic issue_write(input axi_addr_t r);
        exp_b.push_back(expected_write(r));
        apply_write(r);
        s_aw       = r;
        s_aw_valid = 1'b1;
        handshake(0, "the write address to be taken");
        s_aw_valid = 1'b0;
        for (int i = 0; i <= int'(r.len); i++) begin
            s_w.data  = beat_data[i];
            s_w.strb  = beat_strb[i];
            s_w.last  = i == int'(r.len);
            s_w_valid = 1'b1;
            handshake(1, "a write data beat to be taken");
        end
        s_w_valid = 1'b0;
    endtask

    task automatic write_burst(input axi_addr_t r);
        issue_write(r);
        wait_responses(1'b0, "the write response");
    endtask

    // Hands over the read address, the data beats are left outstanding
    task automatic start_read(input axi_addr_t r);
        for (int i = 0; i <= int'(r.len); i++) begin
            exp_r.push_back(expected_read(r, i));
        end
        s_ar       = r;
        s_ar_valid = 1'b1;
        handshake(2, "the read address to be taken");
        s_ar_valid = 1'b0;
    endtask

    task automatic read_burst(input axi_addr_t r);
        start_read(r);
        wait_responses(1'b1, "the read data beats");
    endtask

    always @(posedge clock) begin
        #0.5;
        if (backpressure) begin
            s_b_ready = 1'($urandom);
            s_r_ready = 1'($urandom);
        end else begin
            s_b_ready = 1'b1;
            s_r_ready = 1'b1;
        end
    end

    // Handshake inputs settle after the rising edge, so mid-cycle shows what will transfer
    always @(negedge clock) begin
        axi_rdata_t r_exp;
        axi_bresp_t b_exp;
        if (reset && s_r_valid && s_r_ready) begin
            if (exp_r.size() == 0) begin
                abort_run({"A read beat arrived with no read outstanding in test ", test_name});
            end else begin
                r_exp = exp_r.pop_front();
                check({test_name, " R beat"}, 64'(r_exp), 64'(s_r));
            end
        end
        if (reset && s_b_valid && s_b_ready) begin
            if (exp_b.size() == 0) begin
                abort_run({"A write response arrived with no write outstanding in test ",
                           test_name});
            end else begin
                b_exp = exp_b.pop_front();
                check({test_name, " B"}, 64'(b_exp), 64'(s_b));
            end
        end
    end

    initial begin
        reset      = 1'b0;
        s_aw_valid = 1'b0;
        s_aw       = '0;
        s_w_valid  = 1'b0;
        s_w        = '0;
        s_ar_valid = 1'b0;
        s_ar       = '0;
        void'($urandom(32'hd687_7754));
        repeat (2) @(posedge clock);
        #0.5;
        reset = 1'b1;

        // Every word gets a known value before anything is read
        test_name = "fill";
        for (int base = 0; base < `MEM_WORDS; base += 16) begin
            for (int i = 0; i < 16; i++) begin
                beat_data[i] = fill_word(32'((base + i) * BYTES));
                beat_strb[i] = '1;
            end
            write_burst(make_req(4'(base / 16), base, 15, INCR));
        end

        test_name = "single beat";
        req = make_req(4'h3, 16, 0, INCR);
        beat_data[0] = $urandom;
        beat_strb[0] = '1;
        write_burst(req);
        read_burst(req);

        test_name = "incr bursts";
        for (int t = 0; t < 8; t++) begin
            len  = $urandom_range(15);
            word = $urandom_range(`MEM_WORDS - 1 - len);
            req  = make_req(4'($urandom), word, len, INCR);
            random_beats(len);
            write_burst(req);
            read_burst(req);
        end

        test_name = "fixed burst";
        req = make_req(4'h5, 200, 3, FIXED);
        random_beats(3);
        write_burst(req);
        read_burst(req);

        test_name = "wrap burst";
        req = make_req(4'h6, 133, 7, WRAP);
        random_beats(7);
        write_burst(req);
        read_burst(req);
        read_burst(make_req(4'h7, 128, 7, INCR));

        test_name = "wrap illegal length";
        req = make_req(4'h8, 64, 2, WRAP);
        random_beats(2);
        write_burst(req);
        read_burst(req);
        read_burst(make_req(4'h9, 64, 3, INCR));

        test_name = "top of memory";
        req = make_req(4'ha, `MEM_WORDS - 4, 7, INCR);
        random_beats(7);
        write_burst(req);
        read_burst(req);
        read_burst(make_req(4'hb, `MEM_WORDS - 8, 7, INCR));
        // Dropped beats must not alias onto the bottom of the array
        read_burst(make_req(4'hc, 0, 3, INCR));

        // Writes stay in the lower half and reads in the upper half, so they never overlap
        test_name = "concurrent";
        for (int k = 0; k < 6; k++) begin
            len        = $urandom_range(15);
            word       = $urandom_range(`MEM_WORDS / 2 - 16);
            wr_reqs[k] = make_req(4'($urandom), word, len, INCR);
            len        = $urandom_range(15);
            word       = `MEM_WORDS / 2 + $urandom_range(`MEM_WORDS / 2 - 16);
            rd_reqs[k] = make_req(4'($urandom), word, len, INCR);
        end
        backpressure = 1'b1;
        // Each side queues its bursts back to back, so requests stall in the slice
        fork
            begin
                for (int k = 0; k < 6; k++) begin
                    for (int i = 0; i < 16; i++) begin
                        beat_data[i] = (32'(k * 16 + i + 1) * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
                        beat_strb[i] = '1;
                    end
                    issue_write(wr_reqs[k]);
                end
                wait_responses(1'b0, "the write responses");
            end
            begin
                for (int k = 0; k < 6; k++) begin
                    start_read(rd_reqs[k]);
                end
                wait_responses(1'b1, "the read data beats");
            end
        join
        backpressure = 1'b0;
        for (int base = 0; base < `MEM_WORDS / 2; base += 16) begin
            read_burst(make_req(4'(base / 16), base, 15, INCR));
        end

        if (i_dut.slice.handshake_checks.failures == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("A handshake assertion failed during the run");
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/axi_slice_pkg.sv
src/axi_skid_buffer.sv
src/axi_register_slice.sv
src/axi_burst_memory.sv
src/axi_slice_top.sv
verification/axi_slice_checker.sv
verification/axi_slice_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the AXI4 slice testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" &&
    verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
        --top-module axi_slice_tb -f vlog.f -o axi_slice_sim &&
    ./obj_dir/axi_slice_sim ||
    exit 1
